// File: design/fetch_pkg.sv
package fetch_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int line_words = 4; // also the refill burst length

  localparam logic [data_w-1:0] nop_inst = 32'h0000_0013; // addi x0, x0, 0

  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [1:0] resp_okay = 2'b00;

  // read address channel
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [7:0]        len;   // beats minus one
    logic [1:0]        burst;
  } axi_ar_t;

  // read data channel
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  typedef enum logic [1:0] {
    ic_lookup,
    ic_refill_req,
    ic_refill_wait,
    ic_refill_done  // tag write cycle
  } icache_state_e;

  typedef enum logic [1:0] {
    rdm_idle,
    rdm_addr,
    rdm_data
  } rdm_state_e;

endpackage

// File: design/fetch_pc.sv
`timescale 1ns/10ps

module fetch_pc #(
  parameter logic [fetch_pkg::addr_w-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          advance_i,
  input  logic                          redirect_i,
  input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,
  output logic [fetch_pkg::addr_w-1:0]  pc_o
);

  logic [fetch_pkg::addr_w-1:0] pc_q;
  logic [fetch_pkg::addr_w-1:0] pc_d;

  // redirect wins over sequential advance
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance_i) begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: design/icache.sv
`timescale 1ns/10ps

module icache #(
  parameter int ICACHE_LINES = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [fetch_pkg::addr_w-1:0]  pc_i,
  input  logic                          stall_i,
  input  logic                          redirect_i,
  output logic                          advance_o,
  output logic [fetch_pkg::data_w-1:0]  inst_o,
  output logic [fetch_pkg::addr_w-1:0]  pc_o,
  output logic                          inst_valid_o,
  output logic                          refill_o,
  output logic [fetch_pkg::addr_w-1:0]  refill_addr_o,
  input  logic                          beat_valid_i,
  input  logic [fetch_pkg::data_w-1:0]  beat_data_i,
  input  logic                          refill_done_i
);

  localparam int off_w = $clog2(fetch_pkg::line_words);
  localparam int idx_w = $clog2(ICACHE_LINES);
  localparam int tag_w = fetch_pkg::addr_w - idx_w - off_w - 2;

  logic [fetch_pkg::data_w-1:0] data_q [ICACHE_LINES][fetch_pkg::line_words];
  logic [tag_w-1:0]             tag_q [ICACHE_LINES];
  logic [ICACHE_LINES-1:0]      valid_q;

  fetch_pkg::icache_state_e     state_q;
  logic [fetch_pkg::addr_w-1:0] refill_addr_q;
  logic [off_w-1:0]             beat_cnt_q;
  logic [fetch_pkg::data_w-1:0] inst_q;
  logic [fetch_pkg::addr_w-1:0] pc_q;
  logic                         inst_valid_q;

  logic [idx_w-1:0] idx;
  logic [tag_w-1:0] tag;
  logic [off_w-1:0] word;
  logic [idx_w-1:0] fill_idx;
  logic [tag_w-1:0] fill_tag;
  logic             lookup;
  logic             hit;
  logic             deliver;
  logic             miss;

  assign idx      = pc_i[idx_w+off_w+1:off_w+2];
  assign tag      = pc_i[fetch_pkg::addr_w-1:idx_w+off_w+2];
  assign word     = pc_i[off_w+1:2];
  assign fill_idx = refill_addr_q[idx_w+off_w+1:off_w+2];
  assign fill_tag = refill_addr_q[fetch_pkg::addr_w-1:idx_w+off_w+2];

  assign lookup    = (state_q == fetch_pkg::ic_lookup);
  assign hit       = lookup && valid_q[idx] && (tag_q[idx] == tag);
  assign advance_o = hit && !stall_i;
  assign deliver   = advance_o && !redirect_i; // redirect drops the word
  assign miss      = lookup && !hit && !redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::ic_lookup;
      valid_q      <= '0;
      beat_cnt_q   <= '0;
      inst_valid_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        inst_valid_q <= 1'b0;
      end else if (!stall_i) begin
        inst_valid_q <= deliver; // held while stalled
      end
      case (state_q)
        fetch_pkg::ic_lookup: begin
          if (miss) state_q <= fetch_pkg::ic_refill_req;
        end
        fetch_pkg::ic_refill_req: begin
          beat_cnt_q <= '0;
          state_q    <= fetch_pkg::ic_refill_wait;
        end
        fetch_pkg::ic_refill_wait: begin
          if (beat_valid_i) beat_cnt_q <= beat_cnt_q + 1'b1;
          if (refill_done_i) state_q <= fetch_pkg::ic_refill_done;
        end
        default: begin
          valid_q[fill_idx] <= 1'b1;
          state_q           <= fetch_pkg::ic_lookup;
        end
      endcase
    end
  end

  // arrays and payload
  always_ff @(posedge clk) begin
    if (miss) refill_addr_q <= {pc_i[fetch_pkg::addr_w-1:off_w+2], {(off_w+2){1'b0}}};
    if (state_q == fetch_pkg::ic_refill_wait && beat_valid_i) begin
      data_q[fill_idx][beat_cnt_q] <= beat_data_i;
    end
    if (state_q == fetch_pkg::ic_refill_done) tag_q[fill_idx] <= fill_tag;
    if (deliver) begin
      inst_q <= data_q[idx][word];
      pc_q   <= pc_i;
    end
  end

  assign refill_o      = (state_q == fetch_pkg::ic_refill_req); // one cycle strobe
  assign refill_addr_o = refill_addr_q;
  assign inst_o        = inst_valid_q ? inst_q : fetch_pkg::nop_inst;
  assign pc_o          = pc_q;
  assign inst_valid_o  = inst_valid_q;

endmodule

// File: design/axi_rd_master.sv
`timescale 1ns/10ps

module axi_rd_master (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          refill_i,
  input  logic [fetch_pkg::addr_w-1:0]  refill_addr_i,
  output fetch_pkg::axi_ar_t            ar_o,
  output logic                          ar_valid_o,
  input  logic                          ar_ready_i,
  input  fetch_pkg::axi_r_t             r_i,
  input  logic                          r_valid_i,
  output logic                          r_ready_o,
  output logic                          beat_valid_o,
  output logic [fetch_pkg::data_w-1:0]  beat_data_o,
  output logic                          refill_done_o
);

  fetch_pkg::rdm_state_e        state_q;
  logic [fetch_pkg::addr_w-1:0] addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::rdm_idle;
    end else begin
      case (state_q)
        fetch_pkg::rdm_idle: begin
          if (refill_i) state_q <= fetch_pkg::rdm_addr;
        end
        fetch_pkg::rdm_addr: begin
          if (ar_ready_i) state_q <= fetch_pkg::rdm_data; // AR accepted
        end
        default: begin
          if (r_valid_i && r_i.last) state_q <= fetch_pkg::rdm_idle;
        end
      endcase
    end
  end

  // address stays stable while ar_valid is up
  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::rdm_idle && refill_i) addr_q <= refill_addr_i;
  end

  assign ar_o = '{
    addr:  addr_q,
    len:   8'(fetch_pkg::line_words - 1),
    burst: fetch_pkg::burst_incr
  };
  assign ar_valid_o = (state_q == fetch_pkg::rdm_addr);

  assign r_ready_o     = (state_q == fetch_pkg::rdm_data); // never back-pressures
  assign beat_valid_o  = r_ready_o && r_valid_i;
  assign beat_data_o   = r_i.data;
  assign refill_done_o = beat_valid_o && r_i.last;

endmodule

// File: design/axi_rom_slave.sv
`timescale 1ns/10ps

module axi_rom_slave #(
  parameter int                           RD_LATENCY = 3,
  parameter logic [fetch_pkg::data_w-1:0] ROM_SEED   = 32'h5a5a_0f0f
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::axi_ar_t ar_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  output fetch_pkg::axi_r_t  r_o,
  output logic               r_valid_o,
  input  logic               r_ready_i
);

  localparam int cnt_w = $clog2(RD_LATENCY + 1);

  logic                         busy_q;
  logic [cnt_w-1:0]             lat_q;
  logic [7:0]                   beat_q;
  logic [7:0]                   len_q;
  logic [1:0]                   burst_q;
  logic [fetch_pkg::addr_w-1:0] addr_q;
  logic                         ar_hs;
  logic                         r_hs;
  logic                         last;

  assign ar_ready_o = !busy_q; // one burst at a time
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign r_valid_o  = busy_q && (lat_q == '0);
  assign r_hs       = r_valid_o && r_ready_i;
  assign last       = (beat_q == len_q);

  assign r_o = '{data: addr_q ^ ROM_SEED, resp: fetch_pkg::resp_okay, last: last};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      lat_q  <= '0;
      beat_q <= '0;
    end else if (ar_hs) begin
      busy_q <= 1'b1;
      lat_q  <= cnt_w'(RD_LATENCY - 1); // first beat RD_LATENCY cycles after AR
      beat_q <= '0;
    end else if (busy_q) begin
      if (lat_q != '0) begin
        lat_q <= lat_q - 1'b1;
      end else if (r_hs) begin
        beat_q <= beat_q + 8'd1;
        if (last) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q  <= {ar_i.addr[fetch_pkg::addr_w-1:2], 2'b00}; // word aligned
      len_q   <= ar_i.len;
      burst_q <= ar_i.burst;
    end else if (r_hs && burst_q == fetch_pkg::burst_incr) begin
      addr_q <= addr_q + 32'd4;
    end
  end

endmodule

// File: design/if_stage.sv
`timescale 1ns/10ps

module if_stage #(
  parameter logic [fetch_pkg::addr_w-1:0] RESET_PC     = 32'h8000_0000,
  parameter int                           ICACHE_LINES = 16,
  parameter int                           RD_LATENCY   = 3,
  parameter logic [fetch_pkg::data_w-1:0] ROM_SEED     = 32'h5a5a_0f0f
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall_i,
  input  logic                          redirect_i,
  input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,
  output logic [fetch_pkg::data_w-1:0]  inst_o,
  output logic [fetch_pkg::addr_w-1:0]  pc_o,
  output logic                          inst_valid_o
);

  logic [fetch_pkg::addr_w-1:0] pc;
  logic                         advance;
  logic                         refill;
  logic [fetch_pkg::addr_w-1:0] refill_addr;
  logic                         beat_valid;
  logic [fetch_pkg::data_w-1:0] beat_data;
  logic                         refill_done;

  // read channels between master and memory model
  fetch_pkg::axi_ar_t ar;
  logic               ar_valid;
  logic               ar_ready;
  fetch_pkg::axi_r_t  r;
  logic               r_valid;
  logic               r_ready;

  fetch_pc #(
    .RESET_PC (RESET_PC)
  ) u_fetch_pc (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance_i     (advance),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  icache #(
    .ICACHE_LINES (ICACHE_LINES)
  ) u_icache (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_i          (pc),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .advance_o     (advance),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o),
    .refill_o      (refill),
    .refill_addr_o (refill_addr),
    .beat_valid_i  (beat_valid),
    .beat_data_i   (beat_data),
    .refill_done_i (refill_done)
  );

  axi_rd_master u_axi_rd_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .refill_i      (refill),
    .refill_addr_i (refill_addr),
    .ar_o          (ar),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .r_i           (r),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .beat_valid_o  (beat_valid),
    .beat_data_o   (beat_data),
    .refill_done_o (refill_done)
  );

  axi_rom_slave #(
    .RD_LATENCY (RD_LATENCY),
    .ROM_SEED   (ROM_SEED)
  ) u_axi_rom_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready)
  );

endmodule

// File: test/if_stage_properties.sv
`timescale 1ns/10ps

module if_stage_properties (
  input logic               clk,
  input logic               rst_n,
  input fetch_pkg::axi_ar_t ar_i,
  input logic               ar_valid_i,
  input logic               ar_ready_i,
  input fetch_pkg::axi_r_t  r_i,
  input logic               r_valid_i,
  input logic               r_ready_i,
  input logic               inst_valid_i
);

  logic in_burst_q; // between AR accept and the last R beat

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_burst_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_i) begin
      in_burst_q <= 1'b1;
    end else if (r_valid_i && r_ready_i && r_i.last) begin
      in_burst_q <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else $error("AR valid dropped or payload changed before ready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R valid dropped or payload changed before ready");

  r_ready_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
    r_ready_i |-> in_burst_q)
    else $error("r_ready high outside a burst");

  no_valid_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !inst_valid_i)
    else $error("inst_valid_o high in the first cycle after reset");

endmodule

bind if_stage if_stage_properties props (
  .clk          (clk),
  .rst_n        (rst_n),
  .ar_i         (ar),
  .ar_valid_i   (ar_valid),
  .ar_ready_i   (ar_ready),
  .r_i          (r),
  .r_valid_i    (r_valid),
  .r_ready_i    (r_ready),
  .inst_valid_i (inst_valid_o)
);

// File: test/tb_if_stage.sv
`timescale 1ns/10ps

module tb_if_stage;

  localparam logic [31:0] reset_pc    = 32'h8000_0000;
  localparam logic [31:0] rom_seed    = 32'h1357_9bdf;
  localparam int          cache_lines = 16;
  localparam int          rd_latency  = 3;
  localparam int          wait_limit  = 100; // cycles per wait

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        inst_valid;

  int          value_errors = 0;
  int          other_errors = 0;
  int          delivered    = 0; // instructions checked against the model
  integer      seed;
  logic [31:0] model_pc      = reset_pc;
  logic        stall_seen    = 1'b0; // stall as sampled by the last edge
  logic        redirect_seen = 1'b0;
  logic [31:0] last_inst;
  logic [31:0] last_pc;
  logic        last_valid;

  if_stage #(
    .RESET_PC     (reset_pc),
    .ICACHE_LINES (cache_lines),
    .RD_LATENCY   (rd_latency),
    .ROM_SEED     (rom_seed)
  ) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .inst_o        (inst),
    .pc_o          (pc),
    .inst_valid_o  (inst_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory word is the aligned address xor the seed
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ rom_seed;
  endfunction

  // compare on the falling edge, outputs and inputs both settled
  always @(negedge clk) begin
    if (inst_valid && !stall_seen) begin
      assert (pc === model_pc) else begin
        value_errors++;
        $display("FAIL at %0t ns: pc_o %h, expected %h", $time, pc, model_pc);
      end
      assert (inst === expected_inst(model_pc)) else begin
        value_errors++;
        $display("FAIL at %0t ns: inst_o %h, expected %h", $time, inst, expected_inst(model_pc));
      end
      delivered++;
      model_pc = model_pc + 32'd4;
    end
    if (stall_seen && !redirect_seen) begin
      assert (inst_valid === last_valid && pc === last_pc && inst === last_inst) else begin
        value_errors++;
        $display("FAIL at %0t ns: outputs changed during stall", $time);
      end
    end
    if (!inst_valid) begin
      assert (inst === fetch_pkg::nop_inst) else begin
        value_errors++;
        $display("FAIL at %0t ns: inst_o %h while invalid, expected nop", $time, inst);
      end
    end
    if (redirect) model_pc = redirect_pc;
    stall_seen    = stall;
    redirect_seen = redirect;
    last_valid    = inst_valid;
    last_pc       = pc;
    last_inst     = inst;
  end

  task automatic apply_redirect(input logic [31:0] target);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  task automatic wait_valid(input string what, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < wait_limit) begin
      @(negedge clk);
      ok = inst_valid;
      n++;
    end
    if (!ok) begin
      other_errors++;
      $display("timeout: no valid instruction came while waiting for %s", what);
    end
  endtask

  task automatic wait_for_count(input int target, input string what);
    int n;
    n = 0;
    while (delivered < target && n < 4 * wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (delivered < target) begin
      other_errors++;
      $display("timeout: too few instructions arrived while waiting for %s", what);
    end
  endtask

  task automatic wait_refill(input string what);
    int n;
    n = 0;
    while (!dut.ar_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!dut.ar_valid) begin
      other_errors++;
      $display("timeout: no refill request seen while waiting for %s", what);
    end
  endtask

  initial begin
    bit          ok;
    int          count_before;
    logic [31:0] far_pc;
    seed        = 37059;
    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // cold fetch through the first word of the fourth line
    wait_for_count(3 * fetch_pkg::line_words + 1, "cold fetch");

    // back to a cached line, one word per cycle
    apply_redirect(reset_pc);
    @(negedge clk); // redirect bubble
    repeat (fetch_pkg::line_words) begin
      @(negedge clk);
      assert (inst_valid) else begin
        value_errors++;
        $display("FAIL at %0t ns: hit stream broke, inst_valid_o low", $time);
      end
    end

    // second redirect while the first miss refills
    far_pc = reset_pc + 32'h0000_1008;
    apply_redirect(far_pc);
    wait_refill("miss after redirect");
    apply_redirect(far_pc + 32'h0000_0400);
    wait_valid("fetch after redirect during miss", ok);
    assert (pc === far_pc + 32'h0000_0400 && inst === expected_inst(far_pc + 32'h0000_0400))
    else begin
      value_errors++;
      $display("FAIL at %0t ns: first fetch after redirect has pc_o %h", $time, pc);
    end

    // stall in the middle of a stream
    @(posedge clk);
    wait_for_count(delivered + 2, "stream before stall");
    @(posedge clk);
    stall <= 1'b1;
    repeat (5) @(posedge clk);
    stall <= 1'b0;
    wait_for_count(delivered + 4, "stream after stall");

    // random stalls and redirects over 256 lines
    count_before = delivered;
    repeat (1500) begin
      @(posedge clk);
      stall <= (($random(seed) & 3) == 0);
      if (($random(seed) & 31) == 0) begin
        redirect    <= 1'b1;
        redirect_pc <= reset_pc + ($random(seed) & 32'h0000_0ffc);
      end else begin
        redirect <= 1'b0;
      end
    end
    @(posedge clk);
    stall    <= 1'b0;
    redirect <= 1'b0;
    repeat (4) @(posedge clk);
    assert (delivered > count_before) else begin
      other_errors++;
      $display("the random run delivered no instructions at all");
    end

    $display("errors: %0d wrong values, %0d other failures, %0d instructions checked",
             value_errors, other_errors, delivered);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: list.f
design/fetch_pkg.sv
design/fetch_pc.sv
design/icache.sv
design/axi_rd_master.sv
design/axi_rom_slave.sv
design/if_stage.sv
test/if_stage_properties.sv
test/tb_if_stage.sv

// File: Bender.yml
package:
  name: if_stage

sources:
  - design/fetch_pkg.sv
  - design/fetch_pc.sv
  - design/icache.sv
  - design/axi_rd_master.sv
  - design/axi_rom_slave.sv
  - design/if_stage.sv
  - target: test
    files:
      - test/if_stage_properties.sv
      - test/tb_if_stage.sv
